/* filelist.f */
+incdir+design
design/chroni_video_pkg.sv
design/chroni_bus_pkg.sv
design/line_wr_if.sv
design/raster_timer.sv
design/line_fetch.sv
design/line_buffer.sv
design/palette_regs.sv
design/chroni_top.sv
verification/chroni_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" && rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module chroni_tb \
   -f filelist.f -o chroni_sim &&
{ ./obj_dir/chroni_sim > sim.log 2>&1 || true; } &&
grep -qx "test passed" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

/* verification/chroni_tb.sv */
`timescale 1ns/1ps
`include "chroni_settings.svh"

module chroni_tb;

   localparam int CLK_PERIOD = 4;
   // Three frames, twice over
   localparam int WATCHDOG_NS = 3 * `CHRONI_V_TOTAL * `CHRONI_H_TOTAL * CLK_PERIOD * 2;
   localparam int ACTIVE_PIXELS = `CHRONI_V_ACTIVE * `CHRONI_H_ACTIVE;
   localparam logic [15:0] FG_WORD = 16'hfd20;
   localparam logic [15:0] BG_WORD = 16'h0841;

   logic        sys_clk = 1'b1;
   logic        arst_n = 1'b1;
   logic        cs;
   logic        cpu_wr_en;
   logic [3:0]  cpu_wr_addr;
   logic [7:0]  cpu_wr_data;
   logic [7:0]  rd_data;
   logic        rd_ack;
   logic        rd_req;
   logic [12:0] rd_addr;
   logic        hsync;
   logic        vsync;
   logic        video_de;
   logic [4:0]  vga_r;
   logic [5:0]  vga_g;
   logic [4:0]  vga_b;

   logic [7:0]  text_bytes [16];
   logic        hs_prev;
   logic        vs_prev;
   logic        de_prev;
   int          hs_low;
   int          vs_low;
   int          hs_per;
   int          vs_per;
   int          hs_falls;
   int          vs_falls;
   int          de_x;
   int          de_line;
   int          pix_checked;
   int          fg_pixels;
   int          bg_pixels;
   logic        exp_bit;
   logic [15:0] exp_rgb;
   logic [15:0] pix_rgb;

   chroni_top dut_i (
      .sys_clk     (sys_clk),
      .arst_n      (arst_n),
      .cs          (cs),
      .cpu_wr_en   (cpu_wr_en),
      .cpu_wr_addr (cpu_wr_addr),
      .cpu_wr_data (cpu_wr_data),
      .rd_data     (rd_data),
      .rd_ack      (rd_ack),
      .rd_req      (rd_req),
      .rd_addr     (rd_addr),
      .hsync       (hsync),
      .vsync       (vsync),
      .video_de    (video_de),
      .vga_r       (vga_r),
      .vga_g       (vga_g),
      .vga_b       (vga_b)
   );

   always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Text screen at the text base, font bytes everywhere else
   function automatic logic [7:0] mem_byte(input logic [12:0] addr);
      logic [12:0] prod;
      prod = addr * 13'd37;
      if (addr >= `CHRONI_TEXT_BASE && addr < `CHRONI_TEXT_BASE + 13'd16) begin
         return text_bytes[addr[3:0]];
      end
      return prod[7:0];
   endfunction

   function automatic logic glyph_bit(input int line, input int x);
      logic [3:0]  t_idx;
      logic [12:0] f_addr;
      logic [7:0]  font;
      t_idx  = 4'((line / `CHRONI_GLYPH) * `CHRONI_COLS + x / `CHRONI_GLYPH);
      f_addr = {2'b00, text_bytes[t_idx], 3'(line % `CHRONI_GLYPH)};
      font   = mem_byte(f_addr);
      // Leftmost pixel is the MSB
      return font[3'(7 - x % `CHRONI_GLYPH)];
   endfunction

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t ns: %s", $time, msg);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic cpu_write(input chroni_bus_pkg::reg_sel_e sel, input logic [7:0] data);
      @(negedge sys_clk);
      cs          = 1'b1;
      cpu_wr_en   = 1'b1;
      cpu_wr_addr = sel;
      cpu_wr_data = data;
      @(negedge sys_clk);
      cs        = 1'b0;
      cpu_wr_en = 1'b0;
   endtask

   // Memory with 0 to 3 wait cycles per read
   initial begin : memory_model
      logic [31:0] rng;
      logic        pending;
      logic [1:0]  wait_left;
      rng       = 32'h60e6;
      pending   = 1'b0;
      wait_left = '0;
      rd_ack    = 1'b0;
      rd_data   = '0;
      for (int i = 0; i < 16; i++) begin
         rng           = xorshift(rng);
         text_bytes[i] = rng[7:0];
      end
      forever begin
         @(negedge sys_clk);
         if (rd_ack) begin
            rd_ack = 1'b0;
         end else if (rd_req) begin
            if (!pending) begin
               rng       = xorshift(rng);
               wait_left = rng[1:0];
               pending   = 1'b1;
            end
            if (wait_left == 2'd0) begin
               rd_data = mem_byte(rd_addr);
               rd_ack  = 1'b1;
               pending = 1'b0;
            end else begin
               wait_left = wait_left - 2'd1;
            end
         end
      end
   end

   assign pix_rgb = {vga_r, vga_g, vga_b};
   assign exp_bit = glyph_bit(de_line, de_x);
   assign exp_rgb = exp_bit ? FG_WORD : BG_WORD;

   // Own view of the raster, rebuilt from the sync and enable outputs
   always @(posedge sys_clk) begin
      if (!arst_n) begin
         hs_prev     <= 1'b1;
         vs_prev     <= 1'b1;
         de_prev     <= 1'b0;
         hs_low      <= 0;
         vs_low      <= 0;
         hs_per      <= 0;
         vs_per      <= 0;
         hs_falls    <= 0;
         vs_falls    <= 0;
         de_x        <= 0;
         de_line     <= 0;
         pix_checked <= 0;
         fg_pixels   <= 0;
         bg_pixels   <= 0;
      end else begin
         hs_prev <= hsync;
         vs_prev <= vsync;
         de_prev <= video_de;
         hs_low  <= hsync ? 0 : hs_low + 1;
         vs_low  <= vsync ? 0 : vs_low + 1;
         hs_per  <= (hs_prev && !hsync) ? 1 : hs_per + 1;
         vs_per  <= (vs_prev && !vsync) ? 1 : vs_per + 1;
         if (hs_prev && !hsync) begin
            hs_falls <= hs_falls + 1;
         end
         if (video_de) begin
            de_x <= de_x + 1;
         end else if (de_prev) begin
            de_x    <= 0;
            de_line <= de_line + 1;
         end
         if (vs_prev && !vsync) begin
            vs_falls <= vs_falls + 1;
            de_line  <= 0;
         end
         if (video_de && vs_falls != 0) begin
            pix_checked <= pix_checked + 1;
            if (exp_bit) begin
               fg_pixels <= fg_pixels + 1;
            end else begin
               bg_pixels <= bg_pixels + 1;
            end
         end
      end
   end

   a_reset_idle: assert property (@(posedge sys_clk)
      (!arst_n || $rose(arst_n)) |-> hsync && vsync && !video_de && !rd_req)
      else report_mismatch("control outputs not idle in reset");

   a_hs_len: assert property (@(posedge sys_clk) disable iff (!arst_n)
      !hs_prev && hsync |-> hs_low == `CHRONI_HS_LEN)
      else report_mismatch("hsync low time is not 32 cycles");

   a_hs_period: assert property (@(posedge sys_clk) disable iff (!arst_n)
      hs_prev && !hsync && hs_falls > 0 |-> hs_per == `CHRONI_H_TOTAL)
      else report_mismatch("hsync period is not 200 cycles");

   a_vs_len: assert property (@(posedge sys_clk) disable iff (!arst_n)
      !vs_prev && vsync |-> vs_low == `CHRONI_VS_LEN * `CHRONI_H_TOTAL)
      else report_mismatch("vsync low time is not 2 lines");

   a_vs_period: assert property (@(posedge sys_clk) disable iff (!arst_n)
      vs_prev && !vsync && vs_falls > 0 |-> vs_per == `CHRONI_V_TOTAL * `CHRONI_H_TOTAL)
      else report_mismatch("vsync period is not 20 lines");

   a_addr_steady: assert property (@(posedge sys_clk) disable iff (!arst_n)
      rd_req && !rd_ack |=> $stable(rd_addr))
      else report_mismatch("rd_addr changed before rd_ack");

   a_ack_drop: assert property (@(posedge sys_clk) disable iff (!arst_n)
      rd_ack |=> !rd_req)
      else report_mismatch("rd_req still high after rd_ack");

   a_addr_range: assert property (@(posedge sys_clk) disable iff (!arst_n)
      rd_req |-> rd_addr < 13'h0800 ||
                 (rd_addr >= `CHRONI_TEXT_BASE && rd_addr <= `CHRONI_TEXT_BASE + 13'd15))
      else report_mismatch("read address outside font and text areas");

   a_line_len: assert property (@(posedge sys_clk) disable iff (!arst_n)
      de_prev && !video_de |-> de_x == `CHRONI_H_ACTIVE)
      else report_mismatch("active line is not 64 pixels");

   a_frame_lines: assert property (@(posedge sys_clk) disable iff (!arst_n)
      vs_prev && !vsync |-> de_line == `CHRONI_V_ACTIVE)
      else report_mismatch("frame does not hold 16 active lines");

   a_pixel: assert property (@(posedge sys_clk) disable iff (!arst_n)
      video_de && vs_falls != 0 |-> pix_rgb == exp_rgb)
      else report_mismatch($sformatf("pixel line %0d x %0d expected %h got %h",
         $sampled(de_line), $sampled(de_x), $sampled(exp_rgb), $sampled(pix_rgb)));

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: three frames did not complete in time");
      $display("test failed");
      $fatal(1, "watchdog expired");
   end

   initial begin : main_seq
      cs          = 1'b0;
      cpu_wr_en   = 1'b0;
      cpu_wr_addr = '0;
      cpu_wr_data = '0;
      @(negedge sys_clk);
      arst_n = 1'b0;
      repeat (4) @(negedge sys_clk);
      arst_n = 1'b1;
      // Entries 5 and 6 in one auto-increment run, lo byte first
      cpu_write(chroni_bus_pkg::REG_PAL_INDEX, 8'd5);
      cpu_write(chroni_bus_pkg::REG_PAL_DATA, FG_WORD[7:0]);
      cpu_write(chroni_bus_pkg::REG_PAL_DATA, FG_WORD[15:8]);
      cpu_write(chroni_bus_pkg::REG_PAL_DATA, BG_WORD[7:0]);
      cpu_write(chroni_bus_pkg::REG_PAL_DATA, BG_WORD[15:8]);
      cpu_write(chroni_bus_pkg::REG_FG, 8'd5);
      cpu_write(chroni_bus_pkg::REG_BG, 8'd6);
      wait (vs_falls == 3);
      @(negedge sys_clk);
      if (pix_checked == 2 * ACTIVE_PIXELS && fg_pixels > 0 && bg_pixels > 0) begin
         $display("test passed");
         $finish;
      end else begin
         $display("Pixel check incomplete: %0d compared, %0d fg, %0d bg",
                  pix_checked, fg_pixels, bg_pixels);
         $display("test failed");
         $fatal(1, "not every pixel was compared");
      end
   end

endmodule

/* design/chroni_top.sv */
`timescale 1ns/1ps

module chroni_top (
   input  logic        sys_clk,
   input  logic        arst_n,
   input  logic        cs,
   input  logic        cpu_wr_en,
   input  logic [3:0]  cpu_wr_addr,
   input  logic [7:0]  cpu_wr_data,
   input  logic [7:0]  rd_data,
   input  logic        rd_ack,
   output logic        rd_req,
   output logic [12:0] rd_addr,
   output logic        hsync,
   output logic        vsync,
   output logic        video_de,
   output logic [4:0]  vga_r,
   output logic [5:0]  vga_g,
   output logic [4:0]  vga_b
);

   logic                         line_start;
   logic                         next_row;
   logic [2:0]                   next_scan;
   logic                         buf_half;
   logic [5:0]                   pix_x;
   chroni_video_pkg::pal_index_t fg_index;
   chroni_video_pkg::pal_index_t bg_index;
   chroni_video_pkg::pal_index_t pix_index;
   chroni_video_pkg::rgb565_t    rgb;

   line_wr_if wr_bus ();

   raster_timer raster_i (
      .sys_clk    (sys_clk),
      .arst_n     (arst_n),
      .line_start (line_start),
      .next_row   (next_row),
      .next_scan  (next_scan),
      .buf_half   (buf_half),
      .pix_x      (pix_x),
      .pix_active (),
      .hsync      (hsync),
      .vsync      (vsync),
      .video_de   (video_de)
   );

   line_fetch fetch_i (
      .sys_clk    (sys_clk),
      .arst_n     (arst_n),
      .line_start (line_start),
      .next_row   (next_row),
      .next_scan  (next_scan),
      .buf_half   (buf_half),
      .rd_req     (rd_req),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .rd_ack     (rd_ack),
      .wr         (wr_bus)
   );

   line_buffer buffer_i (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .wr        (wr_bus),
      .pix_x     (pix_x),
      .buf_half  (buf_half),
      .fg_index  (fg_index),
      .bg_index  (bg_index),
      .pix_index (pix_index)
   );

   palette_regs palette_i (
      .sys_clk     (sys_clk),
      .arst_n      (arst_n),
      .cs          (cs),
      .cpu_wr_en   (cpu_wr_en),
      .cpu_wr_addr (cpu_wr_addr),
      .cpu_wr_data (cpu_wr_data),
      .pix_index   (pix_index),
      .fg_index    (fg_index),
      .bg_index    (bg_index),
      .rgb         (rgb)
   );

   assign vga_r = rgb.r;
   assign vga_g = rgb.g;
   assign vga_b = rgb.b;

endmodule

/* design/palette_regs.sv */
`timescale 1ns/1ps

module palette_regs (
   input  logic                         sys_clk,
   input  logic                         arst_n,
   input  logic                         cs,
   input  logic                         cpu_wr_en,
   input  logic [3:0]                   cpu_wr_addr,
   input  logic [7:0]                   cpu_wr_data,
   input  chroni_video_pkg::pal_index_t pix_index,
   output chroni_video_pkg::pal_index_t fg_index,
   output chroni_video_pkg::pal_index_t bg_index,
   output chroni_video_pkg::rgb565_t    rgb
);

   typedef enum logic [1:0] {PAL_IDLE, PAL_LO, PAL_HI, PAL_COMMIT} pal_seq_e;

   pal_seq_e                     seq_state;
   chroni_bus_pkg::reg_sel_e     sel;
   chroni_video_pkg::pal_index_t pal_index;
   chroni_video_pkg::pal_word_u  pal_word;
   chroni_video_pkg::rgb565_t    pal_ram [256];
   logic                         cpu_wr;
   logic                         commit;

   assign sel    = chroni_bus_pkg::reg_sel_e'(cpu_wr_addr);
   assign cpu_wr = cs && cpu_wr_en;
   // A finished word waits for a cycle free of CPU writes
   assign commit = (seq_state == PAL_COMMIT) && !cpu_wr;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         seq_state <= PAL_IDLE;
         pal_index <= '0;
         fg_index  <= '0;
         bg_index  <= '0;
      end else if (cpu_wr) begin
         case (sel)
            chroni_bus_pkg::REG_FG: fg_index <= cpu_wr_data;
            chroni_bus_pkg::REG_BG: bg_index <= cpu_wr_data;
            chroni_bus_pkg::REG_PAL_INDEX: begin
               pal_index <= cpu_wr_data;
               seq_state <= PAL_LO;
            end
            chroni_bus_pkg::REG_PAL_DATA:
               if (seq_state == PAL_LO) begin
                  seq_state <= PAL_HI;
               end else if (seq_state == PAL_HI) begin
                  seq_state <= PAL_COMMIT;
               end
            default: ;
         endcase
      end else if (commit) begin
         // Next data pair goes to the following entry
         pal_index <= pal_index + 8'd1;
         seq_state <= PAL_LO;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (cpu_wr && sel == chroni_bus_pkg::REG_PAL_DATA) begin
         if (seq_state == PAL_LO) begin
            pal_word.bytes.lo <= cpu_wr_data;
         end
         if (seq_state == PAL_HI) begin
            pal_word.bytes.hi <= cpu_wr_data;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (commit) begin
         pal_ram[pal_index] <= pal_word.rgb;
      end
      rgb <= pal_ram[pix_index];
   end

   // Data bytes only arrive while the sequencer expects one
   a_data_expected: assert property (@(posedge sys_clk) disable iff (!arst_n)
      cpu_wr && sel == chroni_bus_pkg::REG_PAL_DATA |->
         seq_state == PAL_LO || seq_state == PAL_HI);

endmodule

/* design/line_buffer.sv */
`timescale 1ns/1ps
`include "chroni_settings.svh"

module line_buffer (
   input  logic                         sys_clk,
   input  logic                         arst_n,
   line_wr_if.buffer                    wr,
   input  logic [5:0]                   pix_x,
   input  logic                         buf_half,
   input  chroni_video_pkg::pal_index_t fg_index,
   input  chroni_video_pkg::pal_index_t bg_index,
   output chroni_video_pkg::pal_index_t pix_index
);

   // Two halves, one per scanline
   chroni_video_pkg::pal_index_t pix_mem [2 * `CHRONI_H_ACTIVE];

   logic       busy;
   logic [2:0] bit_cnt;
   logic [7:0] shift;
   logic [2:0] w_col;
   logic       w_half;

   assign wr.busy = busy;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         busy    <= 1'b0;
         bit_cnt <= '0;
      end else if (wr.wr_en) begin
         busy    <= 1'b1;
         bit_cnt <= '0;
      end else if (busy) begin
         bit_cnt <= bit_cnt + 3'd1;
         if (bit_cnt == 3'd7) begin
            busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (wr.wr_en) begin
         shift  <= wr.glyph;
         w_col  <= wr.col;
         w_half <= wr.half;
      end else if (busy) begin
         shift <= {shift[6:0], 1'b0};
      end
      // Leftmost pixel comes from the MSB
      if (busy) begin
         pix_mem[{w_half, w_col, bit_cnt}] <= shift[7] ? fg_index : bg_index;
      end
      pix_index <= pix_mem[{buf_half, pix_x}];
   end

   a_no_write_when_busy: assert property (@(posedge sys_clk) disable iff (!arst_n)
      wr.wr_en |-> !busy);

endmodule

/* design/line_fetch.sv */
`timescale 1ns/1ps
`include "chroni_settings.svh"

module line_fetch (
   input  logic                      sys_clk,
   input  logic                      arst_n,
   input  logic                      line_start,
   input  logic                      next_row,
   input  logic [2:0]                next_scan,
   input  logic                      buf_half,
   output logic                      rd_req,
   output chroni_bus_pkg::mem_addr_t rd_addr,
   input  logic [7:0]                rd_data,
   input  logic                      rd_ack,
   line_wr_if.fetch                  wr
);

   typedef enum logic [2:0] {
      F_IDLE,
      F_TEXT_REQ,
      F_TEXT_WAIT,
      F_FONT_REQ,
      F_FONT_WAIT,
      F_FONT_WRITE
   } fetch_state_e;

   fetch_state_e state;
   logic [2:0]   col;
   logic [2:0]   scan;
   logic         row;
   logic         last_col;
   logic [7:0]   text_mem [`CHRONI_COLS];

   assign last_col = (col == 3'(`CHRONI_COLS - 1));

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= F_IDLE;
         rd_req   <= 1'b0;
         col      <= '0;
         scan     <= '0;
         row      <= 1'b0;
         wr.wr_en <= 1'b0;
         wr.half  <= 1'b0;
      end else begin
         wr.wr_en <= 1'b0;
         case (state)
            F_IDLE:
               if (line_start) begin
                  col     <= '0;
                  scan    <= next_scan;
                  row     <= next_row;
                  wr.half <= !buf_half;
                  // Character codes are reloaded on the first scan of a row
                  state   <= (next_scan == 3'd0) ? F_TEXT_REQ : F_FONT_REQ;
               end
            F_TEXT_REQ: begin
               rd_req <= 1'b1;
               state  <= F_TEXT_WAIT;
            end
            F_TEXT_WAIT:
               if (rd_ack) begin
                  rd_req <= 1'b0;
                  col    <= col + 3'd1;
                  state  <= last_col ? F_FONT_REQ : F_TEXT_REQ;
               end
            F_FONT_REQ: begin
               rd_req <= 1'b1;
               state  <= F_FONT_WAIT;
            end
            F_FONT_WAIT:
               if (rd_ack) begin
                  rd_req <= 1'b0;
                  state  <= F_FONT_WRITE;
               end
            F_FONT_WRITE:
               if (!wr.busy) begin
                  wr.wr_en <= 1'b1;
                  col      <= col + 3'd1;
                  state    <= last_col ? F_IDLE : F_FONT_REQ;
               end
            default:
               state <= F_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (state == F_TEXT_REQ) begin
         rd_addr <= `CHRONI_TEXT_BASE + chroni_bus_pkg::mem_addr_t'({row, col});
      end
      if (state == F_FONT_REQ) begin
         rd_addr <= chroni_bus_pkg::mem_addr_t'({text_mem[col], scan});
      end
      if (state == F_TEXT_WAIT && rd_ack) begin
         text_mem[col] <= rd_data;
      end
      if (state == F_FONT_WAIT && rd_ack) begin
         wr.glyph <= rd_data;
      end
      if (state == F_FONT_WRITE && !wr.busy) begin
         wr.col <= col;
      end
   end

   a_addr_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
      rd_req && !rd_ack |=> $stable(rd_addr));

   // The whole line must be fetched before the raster asks for the next one
   a_idle_at_line: assert property (@(posedge sys_clk) disable iff (!arst_n)
      line_start |-> state == F_IDLE);

endmodule

/* design/raster_timer.sv */
`timescale 1ns/1ps
`include "chroni_settings.svh"

module raster_timer (
   input  logic       sys_clk,
   input  logic       arst_n,
   output logic       line_start,
   output logic       next_row,
   output logic [2:0] next_scan,
   output logic       buf_half,
   output logic [5:0] pix_x,
   output logic       pix_active,
   output logic       hsync,
   output logic       vsync,
   output logic       video_de
);

   logic [7:0] h_cnt;
   logic [4:0] v_cnt;
   logic [4:0] next_line;
   logic       hs_raw;
   logic       vs_raw;
   logic [`CHRONI_PIPE-1:0] hs_pipe;
   logic [`CHRONI_PIPE-1:0] vs_pipe;
   logic [`CHRONI_PIPE-1:0] de_pipe;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_cnt == 8'(`CHRONI_H_TOTAL - 1)) begin
         h_cnt <= '0;
         v_cnt <= next_line;
      end else begin
         h_cnt <= h_cnt + 8'd1;
      end
   end

   // Line 0 is prepared during the last line of the frame
   assign next_line = (v_cnt == 5'(`CHRONI_V_TOTAL - 1)) ? 5'd0 : v_cnt + 5'd1;
   assign next_scan = 3'(next_line % `CHRONI_GLYPH);
   assign next_row  = 1'(next_line / `CHRONI_GLYPH);

   // Only lines that hold text need a fetch
   assign line_start = (h_cnt == 8'd0) &&
                       (next_line < 5'(`CHRONI_ROWS * `CHRONI_GLYPH));

   assign buf_half   = v_cnt[0];
   assign pix_active = (h_cnt < 8'(`CHRONI_H_ACTIVE)) && (v_cnt < 5'(`CHRONI_V_ACTIVE));
   assign pix_x      = pix_active ? h_cnt[5:0] : 6'd0;

   assign hs_raw = !((h_cnt >= 8'(`CHRONI_HS_START)) &&
                     (h_cnt < 8'(`CHRONI_HS_START + `CHRONI_HS_LEN)));
   assign vs_raw = !((v_cnt >= 5'(`CHRONI_VS_START)) &&
                     (v_cnt < 5'(`CHRONI_VS_START + `CHRONI_VS_LEN)));

   // Align sync and enable with the pixel data path
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         hs_pipe <= '1;
         vs_pipe <= '1;
         de_pipe <= '0;
      end else begin
         hs_pipe <= {hs_pipe[`CHRONI_PIPE-2:0], hs_raw};
         vs_pipe <= {vs_pipe[`CHRONI_PIPE-2:0], vs_raw};
         de_pipe <= {de_pipe[`CHRONI_PIPE-2:0], pix_active};
      end
   end

   assign hsync    = hs_pipe[`CHRONI_PIPE-1];
   assign vsync    = vs_pipe[`CHRONI_PIPE-1];
   assign video_de = de_pipe[`CHRONI_PIPE-1];

endmodule

/* design/line_wr_if.sv */
`timescale 1ns/1ps

interface line_wr_if;
   logic [7:0] glyph;
   logic [2:0] col;
   logic       half;
   logic       wr_en;
   // High while the buffer expands a glyph byte
   logic       busy;

   modport fetch (output glyph, col, half, wr_en, input busy);
   modport buffer (input glyph, col, half, wr_en, output busy);
endinterface

/* design/chroni_bus_pkg.sv */
package chroni_bus_pkg;

   // CPU register map
   typedef enum logic [3:0] {
      REG_FG        = 4'd0,
      REG_BG        = 4'd1,
      REG_PAL_INDEX = 4'd2,
      REG_PAL_DATA  = 4'd3
   } reg_sel_e;

   typedef logic [12:0] mem_addr_t;

endpackage

/* design/chroni_video_pkg.sv */
package chroni_video_pkg;

   typedef logic [7:0] pal_index_t;

   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } rgb565_t;

   // Byte view of a palette word as the CPU loads it
   typedef struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
   } pal_bytes_t;

   typedef union packed {
      rgb565_t    rgb;
      pal_bytes_t bytes;
   } pal_word_u;

endpackage

/* design/chroni_settings.svh */
`ifndef CHRONI_SETTINGS_SVH
`define CHRONI_SETTINGS_SVH

// Text screen geometry
`define CHRONI_COLS       8
`define CHRONI_ROWS       2
`define CHRONI_GLYPH      8

// Raster timing, one cycle per pixel
`define CHRONI_H_TOTAL    200
`define CHRONI_H_ACTIVE   64
`define CHRONI_HS_START   80
`define CHRONI_HS_LEN     32
`define CHRONI_V_TOTAL    20
`define CHRONI_V_ACTIVE   16
`define CHRONI_VS_START   17
`define CHRONI_VS_LEN     2

`define CHRONI_TEXT_BASE  13'h1e00

// Buffer read plus palette read
`define CHRONI_PIPE       2

`endif
